//--- verilog.f
hw/afu_seq_pkg.sv
hw/afu_iteration_counter.sv
hw/afu_address_pattern_gen.sv
hw/afu_seq_fsm.sv
hw/afu_test_sequencer.sv
testbench/tb_afu_test_sequencer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the afu test sequencer testbench with Verilator and runs it
# the run fails when the log holds the fail message or the build breaks

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f \
  --top-module tb_afu_test_sequencer \
  -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  ; cat sim.log 2> /dev/null \
  ; test -s sim.log || { echo "build or simulation did not produce a log"; exit 1; }

grep -q "Test failures found" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "tests run" sim.log || { echo "simulation ended early"; exit 1; }
echo "simulation PASSED"
exit 0

//--- testbench/tb_afu_test_sequencer.sv
//==================================================
// afu test sequencer testbench
// random configurations with stage responders and a
// reference model of the job list and run_error
//==================================================

`timescale 1ns/1ps

module tb_afu_test_sequencer;

  import afu_seq_pkg::*;

  // ==================================================
  // DUT signals
  // ==================================================
  logic          clk = 1'b0;
  logic          reset_n = 1'b0;
  logic          enable_in = 1'b0;
  logic          force_disable = 1'b0;
  seq_config_t   cfg = '0;
  stage_status_t execute_status = '0;
  stage_status_t verify_status = '0;
  logic          execute_start;
  logic          verify_start;
  stage_job_t    job;
  logic          busy;
  logic          run_done;
  logic          run_error;

  // random state with one stream for configurations and one for the stages
  logic [31:0] cfg_lfsr = 32'h6e0b_2e50;
  logic [31:0] stage_lfsr = 32'h6e0b_2e50;

  // stage responder state and what it has seen
  int         exec_wait;
  int         ver_wait;
  logic       exec_bus;
  logic       ver_err;
  int         done_pulses;
  int         verr_target = -1;
  int         ebus_target = -1;
  stage_job_t obs_exec[$];
  stage_job_t obs_ver[$];

  // reference model output
  stage_job_t exp_exec[$];
  stage_job_t exp_ver[$];
  logic       exp_err;

  // bookkeeping
  string current_test;
  int    fail_checks = 0;
  int    checks_at_start;
  int    tests_run = 0;
  int    tests_failed = 0;

  afu_test_sequencer #(
    .loop_count_width (10)
  ) afu_test_sequencer_inst (
    .clk            (clk),
    .reset_n        (reset_n),
    .enable_in      (enable_in),
    .force_disable  (force_disable),
    .cfg            (cfg),
    .execute_status (execute_status),
    .verify_status  (verify_status),
    .execute_start  (execute_start),
    .verify_start   (verify_start),
    .job            (job),
    .busy           (busy),
    .run_done       (run_done),
    .run_error      (run_error)
  );

  initial
  begin
    forever #50 clk = ~clk;
  end

  // galois LFSR with taps 32,22,2,1 that steps once per bit returned
  function automatic logic [63:0] rand_bits(inout logic [31:0] state, input int n);
    logic [63:0] value;
    int          i;
    value = '0;
    for (i = 0; i < n; i++)
    begin
      value = {value[62:0], state[0]};
      state = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    end
    return value;
  endfunction

  // ==================================================
  // stage responders
  // ==================================================

  // each start gets one done pulse after 1 to 8 further edges
  always @(posedge clk)
  begin
    if (!reset_n)
    begin
      execute_status <= '0;
      verify_status  <= '0;
      exec_wait      <= 0;
      ver_wait       <= 0;
      done_pulses    <= 0;
      obs_exec.delete();
      obs_ver.delete();
    end
    else
    begin
      execute_status <= '0;
      verify_status  <= '0;
      if (run_done)
        done_pulses <= done_pulses + 1;
      if (execute_start)
      begin
        exec_bus  <= (obs_exec.size() == ebus_target);
        exec_wait <= int'(rand_bits(stage_lfsr, 3)) + 1;
        obs_exec.push_back(job);
      end
      else if (exec_wait == 1)
      begin
        // fields are done, error_found, bus_error
        execute_status <= {1'b1, 1'b0, exec_bus};
        exec_wait      <= 0;
      end
      else if (exec_wait > 1)
        exec_wait <= exec_wait - 1;
      if (verify_start)
      begin
        ver_err  <= (obs_ver.size() == verr_target);
        ver_wait <= int'(rand_bits(stage_lfsr, 3)) + 1;
        obs_ver.push_back(job);
      end
      else if (ver_wait == 1)
      begin
        verify_status <= {1'b1, ver_err, 1'b0};
        ver_wait      <= 0;
      end
      else if (ver_wait > 1)
        ver_wait <= ver_wait - 1;
    end
  end

  // ==================================================
  // reference model
  // ==================================================

  // set k of the run is set s of its loop and the walk stops at the injected error
  task automatic build_model(input seq_config_t c, input int verr_at, input int ebus_at,
                             input int max_sets);
    int         sets;
    int         loops;
    int         k;
    int         l;
    int         s;
    logic       stop;
    addr_t      stride;
    stage_job_t j;
    exp_exec.delete();
    exp_ver.delete();
    exp_err = 1'b0;
    sets    = (c.number_of_sets[3:0] == 4'd0) ? 1 : int'(c.number_of_sets[3:0]);
    loops   = (c.number_of_loops == 8'd0) ? max_sets : int'(c.number_of_loops);
    stride  = addr_t'(c.set_offset) << 6;
    k       = 0;
    stop    = 1'b0;
    for (l = 0; (l < loops) && !stop && (k < max_sets); l++)
    begin
      for (s = 0; (s < sets) && !stop && (k < max_sets); s++)
      begin
        j.address   = c.base_address + addr_t'(s) * stride;
        j.pattern   = c.pattern_step ?
                      c.base_pattern + pattern_t'(k) * (pattern_t'(c.address_increments) + 32'd1)
                      : c.base_pattern;
        j.set_index = set_index_t'(s);
        if (!c.reads_only)
        begin
          exp_exec.push_back(j);
          if (k == ebus_at)
          begin
            stop    = 1'b1;
            exp_err = 1'b1;
          end
        end
        if (!c.writes_only && !stop)
        begin
          exp_ver.push_back(j);
          // a miscompare only counts when execute wrote the data
          if ((k == verr_at) && !c.reads_only)
          begin
            stop    = 1'b1;
            exp_err = 1'b1;
          end
        end
        k++;
      end
    end
  endtask

  function automatic int total_sets(input seq_config_t c);
    int sets;
    sets = (c.number_of_sets[3:0] == 4'd0) ? 1 : int'(c.number_of_sets[3:0]);
    return sets * int'(c.number_of_loops);
  endfunction

  function automatic seq_config_t random_config();
    seq_config_t c;
    c = '0;
    c.base_address       = addr_t'(rand_bits(cfg_lfsr, 52));
    c.set_offset         = set_offset_t'(rand_bits(cfg_lfsr, 32));
    c.base_pattern       = pattern_t'(rand_bits(cfg_lfsr, 32));
    c.address_increments = count8_t'(rand_bits(cfg_lfsr, 8));
    // the upper nibble of the set count is noise the DUT must ignore
    c.number_of_sets     = {4'(rand_bits(cfg_lfsr, 4)), 4'(rand_bits(cfg_lfsr, 2) + 64'd1)};
    c.number_of_loops    = count8_t'((rand_bits(cfg_lfsr, 2) % 64'd3) + 64'd1);
    c.pattern_step       = 1'(rand_bits(cfg_lfsr, 1));
    return c;
  endfunction

  // ==================================================
  // checks and test framing
  // ==================================================
  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (expected === actual)
    else
    begin
      $display("CHECK FAILED %s: %s expected %0h actual %0h",
               current_test, what, expected, actual);
      fail_checks++;
    end
  endtask

  task automatic compare_queue(input string what, input stage_job_t expected[$],
                               input stage_job_t observed[$], input logic exact);
    int i;
    if (exact)
      check_value({what, " start count"}, 64'(expected.size()), 64'(observed.size()));
    for (i = 0; (i < observed.size()) && (i < expected.size()); i++)
    begin
      check_value($sformatf("%s job %0d address", what, i),
                  64'(expected[i].address), 64'(observed[i].address));
      check_value($sformatf("%s job %0d pattern", what, i),
                  64'(expected[i].pattern), 64'(observed[i].pattern));
      check_value($sformatf("%s job %0d set index", what, i),
                  64'(expected[i].set_index), 64'(observed[i].set_index));
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset_n       <= 1'b0;
    enable_in     <= 1'b0;
    force_disable <= 1'b0;
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;
  endtask

  task automatic begin_test(input string name);
    current_test    = name;
    checks_at_start = fail_checks;
    verr_target     = -1;
    ebus_target     = -1;
    apply_reset();
  endtask

  task automatic end_test();
    tests_run++;
    if (fail_checks == checks_at_start)
      $display("test %s: passed", current_test);
    else
    begin
      tests_failed++;
      $display("test %s: failed with %0d errors", current_test, fail_checks - checks_at_start);
    end
  endtask

  // the DUT sees enable_in in IDLE on the edge after it is driven
  task automatic launch(input seq_config_t c);
    @(posedge clk);
    cfg       <= c;
    enable_in <= 1'b1;
    @(posedge clk);
    enable_in <= 1'b0;
  endtask

  task automatic wait_run_done(input int limit);
    int cycles;
    cycles = 0;
    while ((run_done !== 1'b1) && (cycles < limit))
    begin
      @(negedge clk);
      cycles++;
    end
    assert (run_done === 1'b1)
    else
    begin
      $display("%s: run_done did not arrive within %0d cycles", current_test, limit);
      fail_checks++;
    end
  endtask

  // ==================================================
  // tests
  // ==================================================
  task automatic idle_check();
    int i;
    begin_test("idle_after_reset");
    for (i = 0; i < 10; i++)
    begin
      @(negedge clk);
      check_value("busy", 64'd0, 64'(busy));
      check_value("execute_start", 64'd0, 64'(execute_start));
      check_value("verify_start", 64'd0, 64'(verify_start));
      check_value("run_done", 64'd0, 64'(run_done));
    end
    end_test();
  endtask

  task automatic run_finite(input string name, input seq_config_t c, input int verr_at,
                            input int ebus_at);
    begin_test(name);
    verr_target = verr_at;
    ebus_target = ebus_at;
    build_model(c, verr_at, ebus_at, 1000);
    launch(c);
    wait_run_done(2000);
    check_value("run_error", 64'(exp_err), 64'(run_error));
    @(negedge clk);
    check_value("busy after run_done", 64'd0, 64'(busy));
    // a few quiet cycles expose a stretched or repeated run_done
    repeat (4) @(negedge clk);
    check_value("run_done pulses", 64'd1, 64'(done_pulses));
    compare_queue("execute", exp_exec, obs_exec, 1'b1);
    compare_queue("verify", exp_ver, obs_ver, 1'b1);
    end_test();
  endtask

  task automatic run_endless();
    seq_config_t c;
    int          cycles;
    int          starts_seen;
    begin_test("endless_then_force_disable");
    c = random_config();
    c.number_of_loops = 8'd0;
    build_model(c, -1, -1, 64);
    launch(c);
    cycles = 0;
    while ((obs_ver.size() <= 20) && (cycles < 4000))
    begin
      @(negedge clk);
      cycles++;
    end
    assert (obs_ver.size() > 20)
    else
    begin
      $display("%s: the endless run stopped before 20 sets", current_test);
      fail_checks++;
    end
    check_value("busy while running", 64'd1, 64'(busy));
    @(posedge clk);
    force_disable <= 1'b1;
    @(posedge clk);
    force_disable <= 1'b0;
    // busy drops on the edge that samples the disable
    @(negedge clk);
    check_value("busy after force_disable", 64'd0, 64'(busy));
    starts_seen = obs_exec.size() + obs_ver.size();
    repeat (20) @(negedge clk);
    check_value("starts after force_disable", 64'(starts_seen),
                64'(obs_exec.size() + obs_ver.size()));
    check_value("run_done pulses", 64'd1, 64'(done_pulses));
    check_value("run_error", 64'd0, 64'(run_error));
    compare_queue("execute", exp_exec, obs_exec, 1'b0);
    compare_queue("verify", exp_ver, obs_ver, 1'b0);
    end_test();
  endtask

  initial
  begin
    seq_config_t c;
    int          i;
    idle_check();
    for (i = 0; i < 4; i++)
    begin
      c = random_config();
      run_finite($sformatf("normal_run_%0d", i), c, -1, -1);
    end
    for (i = 0; i < 2; i++)
    begin
      c = random_config();
      c.writes_only = 1'b1;
      run_finite($sformatf("writes_only_%0d", i), c, -1, -1);
      c = random_config();
      c.reads_only = 1'b1;
      run_finite($sformatf("reads_only_%0d", i), c, -1, -1);
    end
    for (i = 0; i < 2; i++)
    begin
      c = random_config();
      run_finite($sformatf("verify_error_%0d", i), c,
                 int'(rand_bits(cfg_lfsr, 8) % 64'(total_sets(c))), -1);
      c = random_config();
      c.reads_only = 1'b1;
      run_finite($sformatf("reads_only_error_ignored_%0d", i), c,
                 int'(rand_bits(cfg_lfsr, 8) % 64'(total_sets(c))), -1);
      c = random_config();
      run_finite($sformatf("execute_bus_error_%0d", i), c, -1,
                 int'(rand_bits(cfg_lfsr, 8) % 64'(total_sets(c))));
    end
    run_endless();
    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, fail_checks);
    if (fail_checks == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

//--- hw/afu_test_sequencer.sv
//==================================================
// afu test sequencer top level
// joins the state machine with the iteration
// counter and the address and pattern generator
//==================================================

`timescale 1ns/1ps

module afu_test_sequencer #(
  parameter int loop_count_width = 10
) (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       enable_in,
  input  logic                       force_disable,
  input  afu_seq_pkg::seq_config_t   cfg,
  input  afu_seq_pkg::stage_status_t execute_status,
  input  afu_seq_pkg::stage_status_t verify_status,
  output logic                       execute_start,
  output logic                       verify_start,
  output afu_seq_pkg::stage_job_t    job,
  output logic                       busy,
  output logic                       run_done,
  output logic                       run_error
);

  // one cycle controls from the state machine
  logic run_start;
  logic loop_start;
  logic set_step;
  logic loop_step;
  // iteration flags back to the state machine
  logic last_set;
  logic last_loop;

  // ==================================================
  // sequencing control
  // ==================================================
  afu_seq_fsm afu_seq_fsm_inst (
    .clk            (clk),
    .reset_n        (reset_n),
    .enable_in      (enable_in),
    .force_disable  (force_disable),
    .cfg            (cfg),
    .execute_status (execute_status),
    .verify_status  (verify_status),
    .last_set       (last_set),
    .last_loop      (last_loop),
    .execute_start  (execute_start),
    .verify_start   (verify_start),
    .run_start      (run_start),
    .loop_start     (loop_start),
    .set_step       (set_step),
    .loop_step      (loop_step),
    .busy           (busy),
    .run_done       (run_done),
    .run_error      (run_error)
  );

  // ==================================================
  // set and loop counting
  // ==================================================
  afu_iteration_counter #(
    .loop_count_width (loop_count_width)
  ) afu_iteration_counter_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .cfg        (cfg),
    .run_start  (run_start),
    .loop_start (loop_start),
    .set_step   (set_step),
    .loop_step  (loop_step),
    .last_set   (last_set),
    .last_loop  (last_loop)
  );

  // job for both stages
  afu_address_pattern_gen afu_address_pattern_gen_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .cfg        (cfg),
    .run_start  (run_start),
    .loop_start (loop_start),
    .set_step   (set_step),
    .job        (job)
  );

endmodule

//--- hw/afu_seq_fsm.sv
//==================================================
// afu sequencer state machine
// orders the execute and verify starts, steps the
// sets and loops and ends the run on error,
// completion or forced disable
//==================================================

`timescale 1ns/1ps

module afu_seq_fsm (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       enable_in,
  input  logic                       force_disable,
  input  afu_seq_pkg::seq_config_t   cfg,
  input  afu_seq_pkg::stage_status_t execute_status,
  input  afu_seq_pkg::stage_status_t verify_status,
  input  logic                       last_set,
  input  logic                       last_loop,
  output logic                       execute_start,
  output logic                       verify_start,
  output logic                       run_start,
  output logic                       loop_start,
  output logic                       set_step,
  output logic                       loop_step,
  output logic                       busy,
  output logic                       run_done,
  output logic                       run_error
);

  import afu_seq_pkg::*;

  seq_state_t state;
  seq_state_t next_state;
  logic       force_stop;
  logic       verify_fail;
  logic       execute_fail;

  // ==================================================
  // stop conditions
  // ==================================================
  always_comb
  begin
    // a forced disable only matters while a run is in flight and not already ending
    force_stop   = force_disable && busy && (state != COMPLETE);
    // a data miscompare is ignored in reads only mode since nothing was written
    verify_fail  = verify_status.bus_error || (verify_status.error_found && !cfg.reads_only);
    execute_fail = execute_status.bus_error;
  end

  // ==================================================
  // state, busy and error registers
  // ==================================================
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      state <= IDLE;
    else if (force_stop)
      // going through COMPLETE keeps the run_done pulse on a disable
      state <= COMPLETE;
    else
      state <= next_state;
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
      busy <= 1'b0;
    else if (force_stop || (state == COMPLETE))
      busy <= 1'b0;
    else if (run_start)
      busy <= 1'b1;
  end

  // the error flag holds after the run so the host can read it with run_done
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      run_error <= 1'b0;
    else if (run_start)
      run_error <= 1'b0;
    else if ((state == EXECUTE_WAIT) && execute_status.done && execute_fail)
      run_error <= 1'b1;
    else if ((state == VERIFY_WAIT) && verify_status.done && verify_fail)
      run_error <= 1'b1;
  end

  // ==================================================
  // next state and one cycle controls
  // ==================================================
  always_comb
  begin
    next_state    = state;
    execute_start = 1'b0;
    verify_start  = 1'b0;
    run_start     = 1'b0;
    loop_start    = 1'b0;
    set_step      = 1'b0;
    loop_step     = 1'b0;
    run_done      = 1'b0;
    case (state)
      IDLE:
      begin
        if (enable_in)
        begin
          run_start  = 1'b1;
          next_state = INIT;
        end
      end
      INIT:
      begin
        // every loop restarts the address walk from the base address
        loop_start = 1'b1;
        next_state = cfg.reads_only ? VERIFY_START : EXECUTE_START;
      end
      EXECUTE_START:
      begin
        execute_start = 1'b1;
        next_state    = EXECUTE_WAIT;
      end
      EXECUTE_WAIT:
      begin
        // stay here until the stage answers, however long it takes
        if (execute_status.done)
        begin
          if (execute_fail)
            next_state = COMPLETE;
          else if (cfg.writes_only)
            next_state = SET_CHECK;
          else
            next_state = VERIFY_START;
        end
      end
      VERIFY_START:
      begin
        verify_start = 1'b1;
        next_state   = VERIFY_WAIT;
      end
      VERIFY_WAIT:
      begin
        if (verify_status.done)
          next_state = CHECK_RESULT;
      end
      CHECK_RESULT:
      begin
        // run_error was captured on the done cycle
        next_state = run_error ? COMPLETE : SET_CHECK;
      end
      SET_CHECK:
      begin
        // the set step also moves the pattern on across loop boundaries
        set_step = 1'b1;
        if (last_set)
        begin
          loop_step  = 1'b1;
          next_state = LOOP_CHECK;
        end
        else
        begin
          next_state = cfg.reads_only ? VERIFY_START : EXECUTE_START;
        end
      end
      LOOP_CHECK:
      begin
        next_state = last_loop ? COMPLETE : INIT;
      end
      COMPLETE:
      begin
        run_done   = 1'b1;
        next_state = IDLE;
      end
      default:
      begin
        next_state = IDLE;
      end
    endcase
  end

endmodule

//--- hw/afu_address_pattern_gen.sv
//==================================================
// afu address and pattern generator
// holds the job for the current set and steps the
// address, set index and pattern between sets
//==================================================

`timescale 1ns/1ps

module afu_address_pattern_gen (
  input  logic                     clk,
  input  logic                     reset_n,
  input  afu_seq_pkg::seq_config_t cfg,
  input  logic                     run_start,
  input  logic                     loop_start,
  input  logic                     set_step,
  output afu_seq_pkg::stage_job_t  job
);

  import afu_seq_pkg::*;

  addr_t      set_stride;
  pattern_t   pattern_incr;
  addr_t      address;
  pattern_t   pattern;
  set_index_t set_index;

  // ==================================================
  // step sizes
  // ==================================================
  always_comb
  begin
    // the raw offset counts cache lines so it is scaled to bytes here
    set_stride   = addr_t'(cfg.set_offset) << set_offset_shift;
    pattern_incr = pattern_t'(cfg.address_increments) + 32'd1;
  end

  // ==================================================
  // address and set index
  // ==================================================

  // address walks from the base once per loop
  always_ff @(posedge clk)
  begin
    if (loop_start)
      address <= cfg.base_address;
    else if (set_step)
      address <= address + set_stride;
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
      set_index <= '0;
    else if (loop_start)
      set_index <= '0;
    else if (set_step)
      set_index <= set_index + 4'd1;
  end

  // ==================================================
  // pattern
  // ==================================================

  // the pattern keeps running across loops and only reloads at a new run
  always_ff @(posedge clk)
  begin
    if (run_start)
      pattern <= cfg.base_pattern;
    else if (set_step)
      pattern <= cfg.pattern_step ? (pattern + pattern_incr) : cfg.base_pattern;
  end

  always_comb
  begin
    job.address   = address;
    job.pattern   = pattern;
    job.set_index = set_index;
  end

endmodule

//--- hw/afu_iteration_counter.sv
//==================================================
// afu iteration counter
// counts sets within a loop and completed loops
// and flags the last set and the last loop
//==================================================

`timescale 1ns/1ps

module afu_iteration_counter #(
  parameter int loop_count_width = 10
) (
  input  logic                     clk,
  input  logic                     reset_n,
  input  afu_seq_pkg::seq_config_t cfg,
  input  logic                     run_start,
  input  logic                     loop_start,
  input  logic                     set_step,
  input  logic                     loop_step,
  output logic                     last_set,
  output logic                     last_loop
);

  import afu_seq_pkg::*;

  set_index_t                  sets_per_loop;
  set_index_t                  set_count;
  logic [loop_count_width-1:0] loops_done;
  logic [loop_count_width-1:0] loops_target;

  // ==================================================
  // limits taken from the configuration
  // ==================================================
  always_comb
  begin
    // a set count of zero still runs one set per loop
    if (cfg.number_of_sets[3:0] == 4'd0)
      sets_per_loop = 4'd1;
    else
      sets_per_loop = set_index_t'(cfg.number_of_sets[3:0]);
    loops_target = loop_count_width'(cfg.number_of_loops);
  end

  // ==================================================
  // counters
  // ==================================================

  // set count restarts at every loop
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      set_count <= '0;
    else if (loop_start)
      set_count <= '0;
    else if (set_step)
      set_count <= set_count + 4'd1;
  end

  // completed loops since the run started
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      loops_done <= '0;
    else if (run_start)
      loops_done <= '0;
    else if (loop_step)
      loops_done <= loops_done + 1'b1;
  end

  always_comb
  begin
    last_set  = (set_count == (sets_per_loop - 4'd1));
    // zero loops means endless so the last loop never comes
    last_loop = (cfg.number_of_loops != 8'd0) && (loops_done == loops_target);
  end

endmodule

//--- hw/afu_seq_pkg.sv
//==================================================
// afu test sequencer package
// shared widths, configuration and job structs,
// stage status and the sequencer state encoding
//==================================================

package afu_seq_pkg;

  // ==================================================
  // widths that carry a meaning
  // ==================================================

  // byte address of a set as seen by the stages
  typedef logic [51:0] addr_t;

  // data pattern written by execute and checked by verify
  typedef logic [31:0] pattern_t;

  // raw set offset as the host writes it
  typedef logic [31:0] set_offset_t;

  // host counts for address increments, sets and loops
  typedef logic [7:0] count8_t;

  // position of a set inside one loop
  typedef logic [3:0] set_index_t;

  // the raw offset is in units of 64 byte lines
  localparam int unsigned set_offset_shift = 6;

  // ==================================================
  // structs
  // ==================================================

  // host configuration that stays stable while the sequencer is busy
  typedef struct packed {
    addr_t       base_address;
    set_offset_t set_offset;
    pattern_t    base_pattern;
    count8_t     address_increments;
    // only the low four bits select the number of sets
    count8_t     number_of_sets;
    // zero here means loop until disabled
    count8_t     number_of_loops;
    logic        pattern_step;
    logic        writes_only;
    logic        reads_only;
  } seq_config_t;

  // work item handed to both stages for the current set
  typedef struct packed {
    addr_t      address;
    pattern_t   pattern;
    set_index_t set_index;
  } stage_job_t;

  // answer of a stage whose error bits count only while done is high
  typedef struct packed {
    logic done;
    logic error_found;
    logic bus_error;
  } stage_status_t;

  // ==================================================
  // sequencer states
  // ==================================================
  typedef enum logic [3:0] {
    IDLE          = 4'd0,
    INIT          = 4'd1,
    EXECUTE_START = 4'd2,
    EXECUTE_WAIT  = 4'd3,
    VERIFY_START  = 4'd4,
    VERIFY_WAIT   = 4'd5,
    CHECK_RESULT  = 4'd6,
    SET_CHECK     = 4'd7,
    LOOP_CHECK    = 4'd8,
    COMPLETE      = 4'd9
  } seq_state_t;

endpackage
